// File: common/soc_pkg.sv
package soc_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;
	localparam int SEL_W  = DATA_W / 8;
	localparam int OFF_W  = 10;
	localparam int SLOT_W = 2;

	typedef logic [DATA_W-1:0] data_t;
	// Word address, the byte bits are not carried on the bus
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [SEL_W-1:0]  sel_t;
	typedef logic [OFF_W-1:0]  off_t;
	typedef logic [SLOT_W-1:0] slot_t;

	// pi1 operation codes
	typedef enum logic [1:0] {
		OP_NOP = 2'b00,
		OP_WR  = 2'b01,
		OP_RD  = 2'b10,
		OP_RW  = 2'b11
	} pi1_op_e;

	typedef struct packed {
		pi1_op_e op;
		addr_t   addr;
		data_t   data;
		sel_t    sel;
	} pi1_req_t;

	// Request after decode, addressed to one slot
	typedef struct packed {
		logic    valid;
		slot_t   slot;
		pi1_op_e op;
		off_t    offset;
		data_t   data;
		sel_t    sel;
	} slot_req_t;

	typedef struct packed {
		logic  valid;
		data_t data;
	} pi1_rsp_t;

	typedef struct packed {
		logic cold;
		logic warm;
		logic pwroff;
	} rst_cmd_t;

	// Slot order is also the address order
	localparam slot_t SLOT_DEVTBL  = 2'd0;
	localparam slot_t SLOT_GPIO    = 2'd1;
	localparam slot_t SLOT_INVALID = 2'd2;
	localparam int    SLOT_COUNT   = 3;

	localparam data_t SLOT_MAPSZ_WORDS [SLOT_COUNT] = '{32'd1024, 32'd1024, 32'd1024};
	localparam logic [7:0] DEV_ID [SLOT_COUNT] = '{8'd7, 8'd6, 8'd0};
	localparam logic DEV_USEINTR [SLOT_COUNT] = '{1'b0, 1'b1, 1'b0};
	localparam data_t SOC_ID = 32'd4;

	// Device table word offsets
	localparam off_t DEVTBL_OFF_COUNT = 10'd0;
	localparam off_t DEVTBL_OFF_SOCID = 10'd1;
	localparam off_t DEVTBL_OFF_SLOTS = 10'd2;

	// GPIO word offsets
	localparam int   GPIO_COUNT   = 8;
	localparam off_t GPIO_OFF_OUT = 10'd0;
	localparam off_t GPIO_OFF_IN  = 10'd1;

	localparam int RST_HOLD_CYCLES = 32;
	localparam int RST_CNTR_W      = 6;

	// Cycles from request to response on the bus
	localparam int RESP_LATENCY = 3;

endpackage

// File: verilog/pi1_addr_decode.sv
module pi1_addr_decode (
	input  logic               clk_2x_w,
	input  logic               rst_p,
	input  logic               sys_rst_i,
	input  soc_pkg::pi1_req_t  req_i,
	output soc_pkg::slot_req_t slot_req_o
);

	import soc_pkg::*;

	addr_t     rem;
	logic      found;
	slot_t     dec_slot;
	slot_req_t slot_req_d;

	// Slots sit back to back from address zero
	always_comb begin
		rem      = req_i.addr;
		found    = 1'b0;
		dec_slot = SLOT_INVALID;
		for (int i = 0; i < int'(SLOT_INVALID); i++) begin
			if (!found) begin
				if (rem < addr_t'(SLOT_MAPSZ_WORDS[i])) begin
					dec_slot = slot_t'(i);
					found    = 1'b1;
				end else begin
					rem = rem - addr_t'(SLOT_MAPSZ_WORDS[i]);
				end
			end
		end
	end

	// Nothing is accepted while the system is held in reset
	always_comb begin
		slot_req_d.valid  = (req_i.op != OP_NOP) && !sys_rst_i;
		slot_req_d.slot   = dec_slot;
		slot_req_d.op     = req_i.op;
		slot_req_d.offset = off_t'(rem);
		slot_req_d.data   = req_i.data;
		slot_req_d.sel    = req_i.sel;
	end

	always_ff @(posedge clk_2x_w) begin
		slot_req_o <= slot_req_d;
		if (rst_p) begin
			slot_req_o.valid <= 1'b0;
		end
	end

endmodule

// File: devtbl/devtbl_regs.sv
module devtbl_regs (
	input  logic               clk_2x_w,
	input  logic               rst_p,
	input  soc_pkg::slot_req_t slot_req_i,
	output soc_pkg::data_t     rdata_o,
	output soc_pkg::rst_cmd_t  rst_cmd_o
);

	import soc_pkg::*;

	logic     hit;
	logic     rd_hit;
	logic     wr_hit;
	data_t    tbl_rdata;
	rst_cmd_t rst_cmd_d;

	assign hit    = slot_req_i.valid && (slot_req_i.slot == SLOT_DEVTBL);
	assign rd_hit = hit && (slot_req_i.op == OP_RD || slot_req_i.op == OP_RW);
	assign wr_hit = hit && (slot_req_i.op == OP_WR || slot_req_i.op == OP_RW);

	// Two words per slot after the header: id word then map size in bytes
	always_comb begin
		tbl_rdata = '0;
		if (slot_req_i.offset == DEVTBL_OFF_COUNT) begin
			tbl_rdata = data_t'(SLOT_COUNT);
		end else if (slot_req_i.offset == DEVTBL_OFF_SOCID) begin
			tbl_rdata = SOC_ID;
		end
		for (int n = 0; n < SLOT_COUNT; n++) begin
			if (slot_req_i.offset == DEVTBL_OFF_SLOTS + off_t'(2 * n)) begin
				tbl_rdata = {DEV_USEINTR[n], 23'd0, DEV_ID[n]};
			end
			if (slot_req_i.offset == DEVTBL_OFF_SLOTS + off_t'(2 * n + 1)) begin
				tbl_rdata = SLOT_MAPSZ_WORDS[n] << 2;
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rd_hit) begin
			rdata_o <= tbl_rdata;
		end
	end

	// Bits 1:0 of the control word: 11 cold, 10 warm, 01 power off
	always_comb begin
		rst_cmd_d = '0;
		if (wr_hit && slot_req_i.offset == DEVTBL_OFF_COUNT && slot_req_i.sel[0]) begin
			case (slot_req_i.data[1:0])
				2'b11: rst_cmd_d.cold = 1'b1;
				2'b10: rst_cmd_d.warm = 1'b1;
				2'b01: rst_cmd_d.pwroff = 1'b1;
				default: rst_cmd_d = '0;
			endcase
		end
	end

	// Single cycle pulse toward the reset sequencer
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			rst_cmd_o <= '0;
		end else begin
			rst_cmd_o <= rst_cmd_d;
		end
	end

endmodule

// File: verilog/gpio_regs.sv
module gpio_regs (
	input  logic                           clk_2x_w,
	input  logic                           sys_rst_i,
	input  soc_pkg::slot_req_t             slot_req_i,
	input  logic [soc_pkg::GPIO_COUNT-1:0] gp_i,
	output soc_pkg::data_t                 rdata_o,
	output logic [soc_pkg::GPIO_COUNT-1:0] gp_o
);

	import soc_pkg::*;

	logic                  hit;
	logic                  rd_hit;
	logic                  wr_hit;
	logic [GPIO_COUNT-1:0] gp_out_q;
	logic [GPIO_COUNT-1:0] gp_meta;
	logic [GPIO_COUNT-1:0] gp_sync;

	assign hit    = slot_req_i.valid && (slot_req_i.slot == SLOT_GPIO);
	assign rd_hit = hit && (slot_req_i.op == OP_RD || slot_req_i.op == OP_RW);
	assign wr_hit = hit && (slot_req_i.op == OP_WR || slot_req_i.op == OP_RW);

	// Inputs come from pins, two flops before use
	always_ff @(posedge clk_2x_w) begin
		gp_meta <= gp_i;
		gp_sync <= gp_meta;
	end

	// All outputs live in byte 0
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			gp_out_q <= '0;
		end else if (wr_hit && slot_req_i.offset == GPIO_OFF_OUT && slot_req_i.sel[0]) begin
			gp_out_q <= slot_req_i.data[GPIO_COUNT-1:0];
		end
	end

	// Sampled before the write lands, so a swap returns the old value
	always_ff @(posedge clk_2x_w) begin
		if (rd_hit) begin
			if (slot_req_i.offset == GPIO_OFF_OUT) begin
				rdata_o <= data_t'(gp_out_q);
			end else if (slot_req_i.offset == GPIO_OFF_IN) begin
				rdata_o <= data_t'(gp_sync);
			end else begin
				rdata_o <= '0;
			end
		end
	end

	assign gp_o = gp_out_q;

endmodule

// File: verilog/pi1_resp_select.sv
module pi1_resp_select (
	input  logic               clk_2x_w,
	input  logic               sys_rst_i,
	input  soc_pkg::slot_req_t slot_req_i,
	input  soc_pkg::data_t     devtbl_rdata_i,
	input  soc_pkg::data_t     gpio_rdata_i,
	output soc_pkg::pi1_rsp_t  rsp_o
);

	import soc_pkg::*;

	slot_t slot_d;
	logic  rd_d;
	data_t sel_rdata;

	// Lines up with the slaves' registered read data
	always_ff @(posedge clk_2x_w) begin
		slot_d <= slot_req_i.slot;
		if (sys_rst_i) begin
			rd_d <= 1'b0;
		end else begin
			rd_d <= slot_req_i.valid && (slot_req_i.op == OP_RD || slot_req_i.op == OP_RW);
		end
	end

	always_comb begin
		case (slot_d)
			SLOT_DEVTBL: sel_rdata = devtbl_rdata_i;
			SLOT_GPIO:   sel_rdata = gpio_rdata_i;
			// Invalid device reads as zero
			default:     sel_rdata = '0;
		endcase
	end

	always_ff @(posedge clk_2x_w) begin
		rsp_o.valid <= rd_d;
		rsp_o.data  <= sel_rdata;
		if (sys_rst_i) begin
			rsp_o.valid <= 1'b0;
		end
	end

endmodule

// File: verilog/rst_seq.sv
module rst_seq (
	input  logic              clk_2x_w,
	input  logic              rst_p,
	input  soc_pkg::rst_cmd_t rst_cmd_i,
	output logic              sys_rst_o
);

	import soc_pkg::*;

	logic [RST_CNTR_W-1:0] hold_cntr;
	logic                  pwroff_q;

	// Board reset, cold and warm all restart the hold period
	always_ff @(posedge clk_2x_w) begin
		if (rst_p || rst_cmd_i.cold || rst_cmd_i.warm) begin
			hold_cntr <= RST_CNTR_W'(RST_HOLD_CYCLES);
		end else if (hold_cntr != '0) begin
			hold_cntr <= hold_cntr - 1'b1;
		end
	end

	// Power off only ends with the board reset
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (rst_cmd_i.pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (hold_cntr != '0) || pwroff_q;

endmodule

// File: verilog/soc_top.sv
module soc_top (
	input  logic                           clk_2x_w,
	input  logic                           rst_p,
	input  soc_pkg::pi1_req_t              req_i,
	input  logic [soc_pkg::GPIO_COUNT-1:0] gp_i,
	output soc_pkg::pi1_rsp_t              rsp_o,
	output logic [soc_pkg::GPIO_COUNT-1:0] gp_o,
	output logic                           sys_rst_o
);

	import soc_pkg::*;

	slot_req_t slot_req_w;
	data_t     devtbl_rdata_w;
	data_t     gpio_rdata_w;
	rst_cmd_t  rst_cmd_w;

	// Address decode stage
	pi1_addr_decode u_decode (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.sys_rst_i  (sys_rst_o),
		.req_i      (req_i),
		.slot_req_o (slot_req_w)
	);

	// Device table, also the source of software resets
	devtbl_regs u_devtbl (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.slot_req_i (slot_req_w),
		.rdata_o    (devtbl_rdata_w),
		.rst_cmd_o  (rst_cmd_w)
	);

	gpio_regs u_gpio (
		.clk_2x_w   (clk_2x_w),
		.sys_rst_i  (sys_rst_o),
		.slot_req_i (slot_req_w),
		.gp_i       (gp_i),
		.rdata_o    (gpio_rdata_w),
		.gp_o       (gp_o)
	);

	// Invalid slot has no module, the response select returns zero for it
	pi1_resp_select u_resp (
		.clk_2x_w       (clk_2x_w),
		.sys_rst_i      (sys_rst_o),
		.slot_req_i     (slot_req_w),
		.devtbl_rdata_i (devtbl_rdata_w),
		.gpio_rdata_i   (gpio_rdata_w),
		.rsp_o          (rsp_o)
	);

	rst_seq u_rst_seq (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.rst_cmd_i (rst_cmd_w),
		.sys_rst_o (sys_rst_o)
	);

endmodule

// File: tb/soc_tb_model.svh
`ifndef SOC_TB_MODEL_SVH
`define SOC_TB_MODEL_SVH

// Reference state kept next to the DUT
logic [31:0]           lcg_state  = 32'd90;
logic [GPIO_COUNT-1:0] model_gp   = '0;
logic [GPIO_COUNT-1:0] model_gpin = '0;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// Low LCG bits repeat quickly, so only upper halves are used
function automatic logic [31:0] rand_word();
	logic [31:0] s1;
	logic [31:0] s2;
	s1 = lcg_step(lcg_state);
	s2 = lcg_step(s1);
	lcg_state = s2;
	return {s1[31:16], s2[31:16]};
endfunction

// Header words, then an id word and a byte size per slot
function automatic data_t devtbl_expect(input off_t off);
	int    n;
	data_t w;
	n = (int'(off) - 2) / 2;
	w = '0;
	if (off == 10'd0) return data_t'(SLOT_COUNT);
	if (off == 10'd1) return SOC_ID;
	if (n < SLOT_COUNT) begin
		if (off[0] == 1'b0) begin
			// Id in the low byte, interrupt flag in the top bit
			w[7:0] = DEV_ID[n];
			w[31]  = DEV_USEINTR[n];
			return w;
		end
		return SLOT_MAPSZ_WORDS[n] * 32'd4;
	end
	return '0;
endfunction

// Drives one bus cycle and the expected read data alongside it
task automatic bus_op(input pi1_op_e op, input addr_t addr, input data_t data, input sel_t sel);
	logic  accepted;
	data_t rdata;
	off_t  off;
	@(posedge clk_2x_w);
	#1;
	accepted = !rst_p && !sys_rst_o && (op != OP_NOP);
	rdata    = '0;
	if (addr < GPIO_BASE) begin
		off   = off_t'(addr);
		rdata = devtbl_expect(off);
	end else if (addr < INVALID_BASE) begin
		off = off_t'(addr - GPIO_BASE);
		if (off == 10'd0) rdata = data_t'(model_gp);
		if (off == 10'd1) rdata = data_t'(model_gpin);
		// Old value is read first, so a swap returns it
		if (accepted && op != OP_RD && off == 10'd0 && sel[0]) begin
			model_gp = data[GPIO_COUNT-1:0];
		end
	end
	req_i.op   = op;
	req_i.addr = addr;
	req_i.data = data;
	req_i.sel  = sel;
	drv_rd     = accepted && (op == OP_RD || op == OP_RW);
	drv_rdata  = rdata;
	drv_gp     = model_gp;
endtask

task automatic idle_cycles(input int n);
	repeat (n) begin
		bus_op(OP_NOP, '0, '0, '0);
	end
endtask

`endif

// File: tb/soc_top_tb.sv
module soc_top_tb;

	import soc_pkg::*;

	localparam int    TIMEOUT_CYCLES = 3000;
	localparam addr_t GPIO_BASE      = addr_t'(SLOT_MAPSZ_WORDS[0]);
	localparam addr_t INVALID_BASE   = addr_t'(SLOT_MAPSZ_WORDS[0] + SLOT_MAPSZ_WORDS[1]);

	logic                  clk_2x_w = 1'b0;
	logic                  rst_p    = 1'b1;
	pi1_req_t              req_i    = '0;
	logic [GPIO_COUNT-1:0] gp_i     = '0;
	pi1_rsp_t              rsp_o;
	logic [GPIO_COUNT-1:0] gp_o;
	logic                  sys_rst_o;

	// Expectations driven together with each request
	logic                  drv_rd    = 1'b0;
	data_t                 drv_rdata = '0;
	logic [GPIO_COUNT-1:0] drv_gp    = '0;

	logic                  exp_valid_q [RESP_LATENCY];
	data_t                 exp_data_q  [RESP_LATENCY];
	logic [GPIO_COUNT-1:0] gp_stage_q;
	logic [GPIO_COUNT-1:0] gp_exp_q;
	int                    cycle_cnt = 0;

	always #4 clk_2x_w = ~clk_2x_w;

	soc_top dut_i (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.req_i     (req_i),
		.gp_i      (gp_i),
		.rsp_o     (rsp_o),
		.gp_o      (gp_o),
		.sys_rst_o (sys_rst_o)
	);

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input data_t exp, input data_t act);
		stop_with_failure($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act));
	endtask

	`include "soc_tb_model.svh"

	// Expected responses run RESP_LATENCY edges deep and a system reset drops all in flight
	always @(posedge clk_2x_w) begin
		if (rst_p || sys_rst_o) begin
			for (int i = 0; i < RESP_LATENCY; i++) begin
				exp_valid_q[i] <= 1'b0;
				exp_data_q[i]  <= '0;
			end
			gp_stage_q <= '0;
			gp_exp_q   <= '0;
		end else begin
			exp_valid_q[0] <= drv_rd;
			exp_data_q[0]  <= drv_rdata;
			for (int i = 1; i < RESP_LATENCY; i++) begin
				exp_valid_q[i] <= exp_valid_q[i-1];
				exp_data_q[i]  <= exp_data_q[i-1];
			end
			// Decode and slave take two edges to the pins
			gp_stage_q <= drv_gp;
			gp_exp_q   <= gp_stage_q;
		end
	end

	assert property (@(posedge clk_2x_w) disable iff (rst_p)
		rsp_o.valid == exp_valid_q[RESP_LATENCY-1])
		else report_mismatch("rsp_o.valid", data_t'(exp_valid_q[RESP_LATENCY-1]),
			data_t'(rsp_o.valid));

	assert property (@(posedge clk_2x_w) disable iff (rst_p)
		!exp_valid_q[RESP_LATENCY-1] || rsp_o.data == exp_data_q[RESP_LATENCY-1])
		else report_mismatch("rsp_o.data", exp_data_q[RESP_LATENCY-1], rsp_o.data);

	assert property (@(posedge clk_2x_w) disable iff (rst_p) gp_o == gp_exp_q)
		else report_mismatch("gp_o", data_t'(gp_exp_q), data_t'(gp_o));

	always @(posedge clk_2x_w) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			stop_with_failure("Run did not finish within the cycle limit");
		end
	end

	// Pulses rst_p, then times the release of sys_rst_o
	task automatic board_reset();
		int n;
		n = 0;
		@(posedge clk_2x_w);
		#1;
		rst_p    = 1'b1;
		req_i    = '0;
		drv_rd   = 1'b0;
		model_gp = '0;
		drv_gp   = '0;
		repeat (10) @(posedge clk_2x_w);
		#1;
		rst_p = 1'b0;
		while (sys_rst_o && n <= RST_HOLD_CYCLES + 1) begin
			@(posedge clk_2x_w);
			#1;
			n++;
			assert (!rsp_o.valid && gp_o == '0)
				else stop_with_failure("Response or GPIO output active during reset hold");
		end
		assert (n >= RST_HOLD_CYCLES - 1 && n <= RST_HOLD_CYCLES + 1)
			else report_mismatch("sys_rst_o hold cycles", data_t'(RST_HOLD_CYCLES), data_t'(n));
	endtask

	task automatic expect_rst_rise();
		int n;
		n = 0;
		while (!sys_rst_o && n < 8) begin
			bus_op(OP_NOP, '0, '0, '0);
			n++;
		end
		assert (sys_rst_o && n <= 4)
			else stop_with_failure("sys_rst_o did not rise within 4 cycles of the reset write");
		model_gp = '0;
	endtask

	// Reads up to the last held cycle must stay unanswered
	task automatic wait_rst_fall();
		int n;
		n = 0;
		while (sys_rst_o && n < RST_HOLD_CYCLES + 8) begin
			bus_op(OP_RD, GPIO_BASE, '0, '0);
			n++;
		end
		assert (!sys_rst_o) else stop_with_failure("sys_rst_o stayed high after a warm reset");
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		board_reset();
		// Device table walk, then one offset past it
		for (int i = 0; i <= 8; i++) begin
			bus_op(OP_RD, addr_t'(i), '0, '0);
		end
		r = rand_word();
		bus_op(OP_RD, addr_t'(9 + r[9:0] % 1015), '0, '0);
		// GPIO output with random byte selects
		repeat (24) begin
			r = rand_word();
			d = rand_word();
			bus_op(OP_WR, GPIO_BASE, d, sel_t'(r));
			bus_op(OP_RD, GPIO_BASE, '0, '0);
		end
		repeat (8) begin
			r = rand_word();
			d = rand_word();
			bus_op(OP_RW, GPIO_BASE, d, sel_t'(r));
		end
		// Synchronised input, then the invalid space
		r          = rand_word();
		gp_i       = r[GPIO_COUNT-1:0];
		model_gpin = gp_i;
		idle_cycles(3);
		bus_op(OP_RD, GPIO_BASE + 1, '0, '0);
		repeat (8) begin
			r = rand_word();
			d = rand_word();
			bus_op(OP_WR, INVALID_BASE + addr_t'(r[19:0]), d, 4'hF);
			bus_op(OP_RD, INVALID_BASE + addr_t'(r[19:0]), '0, '0);
			bus_op(OP_RD, GPIO_BASE, '0, '0);
		end
		// Back-to-back traffic over all slots; device table is only read here
		repeat (200) begin
			r = rand_word();
			d = rand_word();
			case (r[31:24] % 3)
				0:       bus_op(OP_RD, addr_t'(r[4:0]), d, sel_t'(r[11:8]));
				1:       bus_op(pi1_op_e'(r[5:4]), GPIO_BASE + addr_t'(r[7:6]), d, sel_t'(r[11:8]));
				default: bus_op(pi1_op_e'(r[5:4]), INVALID_BASE + addr_t'(r[27:12]), d,
					sel_t'(r[11:8]));
			endcase
		end
		idle_cycles(RESP_LATENCY + 1);
		// Warm reset clears the output register and ignores requests meanwhile
		bus_op(OP_WR, GPIO_BASE, 32'h0000_00A5, 4'h1);
		idle_cycles(3);
		bus_op(OP_WR, '0, 32'h2, 4'h1);
		expect_rst_rise();
		bus_op(OP_RD, GPIO_BASE, '0, '0);
		bus_op(OP_RD, addr_t'(1), '0, '0);
		bus_op(OP_WR, GPIO_BASE, 32'h0000_00FF, 4'hF);
		wait_rst_fall();
		idle_cycles(2);
		assert (gp_o == '0) else report_mismatch("gp_o", '0, data_t'(gp_o));
		bus_op(OP_RD, GPIO_BASE, '0, '0);
		idle_cycles(RESP_LATENCY + 1);
		// Power off holds until the board reset
		bus_op(OP_WR, '0, 32'h1, 4'h1);
		expect_rst_rise();
		repeat (100) begin
			bus_op(OP_RD, addr_t'(1), '0, '0);
			assert (sys_rst_o) else stop_with_failure("sys_rst_o released during power-off");
		end
		board_reset();
		bus_op(OP_RD, addr_t'(1), '0, '0);
		idle_cycles(RESP_LATENCY + 2);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: soc_top.f
+incdir+tb
common/soc_pkg.sv
verilog/pi1_addr_decode.sv
devtbl/devtbl_regs.sv
verilog/gpio_regs.sv
verilog/pi1_resp_select.sv
verilog/rst_seq.sv
verilog/soc_top.sv
tb/soc_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench; the exit status carries the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module soc_top_tb \
	-f soc_top.f \
	-o soc_sim
./obj_dir/soc_sim
